// File: hw/cart_cfg.svh
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

////////////////////////////////////////
// Board geometry
////////////////////////////////////////
`define CART_NUM_BANKS 4          // External SRAM chips
`define CART_SNES_AW 24           // Console address bus
`define CART_PHYS_AW 23           // Folded cart address
`define CART_WORD_AW 20           // 16-bit words per chip

////////////////////////////////////////
// Configuration port
////////////////////////////////////////
`define CART_AXI_AW 32
`define CART_AXI_DW 32
`define CART_REG_MAPPER 'h0
`define CART_REG_ROM_MASK 'h4
`define CART_REG_SAVE_MASK 'h8
`define CART_ROM_MASK_RST 23'h7fffff    // Whole 8 MB visible
`define CART_SAVE_MASK_RST 23'h001fff   // 8 kB save RAM

`endif

// File: hw/cart_pkg.sv
`include "cart_cfg.svh"

package cart_pkg;

   // Mapper codes as written by the controller
   typedef enum logic [2:0] {
      map_hirom   = 3'd0,
      map_lorom   = 3'd1,
      map_exhirom = 3'd2   // 48-64 Mbit images
   } mapper_e;

   // One console or master cycle
   typedef struct packed {
      logic                     valid;
      logic [`CART_SNES_AW-1:0] addr;
      logic                     cs_n;         // CART pin, active low
      logic                     master;       // Controller owns the bus
      logic [`CART_PHYS_AW-1:0] master_addr;
   } bus_req_t;

   // Registered decoder output
   typedef struct packed {
      logic                     valid;
      logic                     is_rom;
      logic                     is_saveram;
      logic [`CART_PHYS_AW-1:0] phys_addr;
      logic                     bank_sel;     // Some chip is addressed
      logic [1:0]               bank;
   } decode_t;

   // Pins toward one SRAM chip
   typedef struct packed {
      logic                     sel;
      logic [`CART_WORD_AW-1:0] word_addr;
      logic                     lane;         // 1 picks the high byte
   } bank_cmd_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } bank_rsp_t;

   // Read byte back to the console side
   typedef struct packed {
      logic                     valid;
      logic                     is_rom;
      logic                     is_saveram;
      logic [`CART_PHYS_AW-1:0] phys_addr;
      logic [7:0]               data;
   } cart_rsp_t;

endpackage

// File: hw/cart_cfg_regs.sv
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_cfg_regs (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`CART_AXI_AW-1:0]    s_awaddr,
   input  logic                       s_awvalid,
   output logic                       s_awready,
   input  logic [`CART_AXI_DW-1:0]    s_wdata,
   input  logic [`CART_AXI_DW/8-1:0]  s_wstrb,
   input  logic                       s_wvalid,
   output logic                       s_wready,
   output logic [1:0]                 s_bresp,
   output logic                       s_bvalid,
   input  logic                       s_bready,
   input  logic [`CART_AXI_AW-1:0]    s_araddr,
   input  logic                       s_arvalid,
   output logic                       s_arready,
   output logic [`CART_AXI_DW-1:0]    s_rdata,
   output logic [1:0]                 s_rresp,
   output logic                       s_rvalid,
   input  logic                       s_rready,
   output cart_pkg::mapper_e          mapper,
   output logic [`CART_PHYS_AW-1:0]   rom_mask,
   output logic [`CART_PHYS_AW-1:0]   save_mask
);
   import cart_pkg::*;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic                      aw_hold;     // Write address captured
   logic                      w_hold;      // Write data captured
   logic [`CART_AXI_AW-1:0]   aw_addr_q;
   logic [`CART_AXI_DW-1:0]   w_data_q;
   logic [`CART_AXI_DW/8-1:0] w_strb_q;
   logic [2:0]                mapper_q;
   logic                      wr_go;
   logic                      rd_go;
   logic [`CART_AXI_DW-1:0]   nxt_mapper;
   logic [`CART_AXI_DW-1:0]   nxt_rom;
   logic [`CART_AXI_DW-1:0]   nxt_save;
   logic [`CART_AXI_DW-1:0]   rd_data;
   logic                      rd_err;

   // Byte-wise merge of new data over the old register
   function automatic logic [`CART_AXI_DW-1:0] strb_merge(
      input logic [`CART_AXI_DW-1:0]   old_v,
      input logic [`CART_AXI_DW-1:0]   new_v,
      input logic [`CART_AXI_DW/8-1:0] strb
   );
      logic [`CART_AXI_DW-1:0] res;
      res = old_v;
      for (int b = 0; b < `CART_AXI_DW/8; b++) begin
         if (strb[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
      end
      return res;
   endfunction

   assign s_awready = !aw_hold;
   assign s_wready  = !w_hold;
   assign wr_go     = aw_hold && w_hold && !s_bvalid;   // Both halves in, B free
   assign s_arready = !s_rvalid;
   assign rd_go     = s_arvalid && s_arready;
   assign mapper    = mapper_e'(mapper_q);

   always_comb begin
      nxt_mapper = strb_merge(`CART_AXI_DW'(mapper_q), w_data_q, w_strb_q);
      nxt_rom    = strb_merge(`CART_AXI_DW'(rom_mask), w_data_q, w_strb_q);
      nxt_save   = strb_merge(`CART_AXI_DW'(save_mask), w_data_q, w_strb_q);
   end

   // Read mux
   always_comb begin
      rd_err = 1'b0;
      case (s_araddr)
         `CART_REG_MAPPER:    rd_data = `CART_AXI_DW'(mapper_q);
         `CART_REG_ROM_MASK:  rd_data = `CART_AXI_DW'(rom_mask);
         `CART_REG_SAVE_MASK: rd_data = `CART_AXI_DW'(save_mask);
         default: begin
            rd_data = '0;
            rd_err  = 1'b1;   // Unmapped offset
         end
      endcase
   end

   ////////////////////////////////////////
   // Handshake state and registers
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aw_hold   <= 1'b0;
         w_hold    <= 1'b0;
         s_bvalid  <= 1'b0;
         s_rvalid  <= 1'b0;
         mapper_q  <= 3'(map_hirom);
         rom_mask  <= `CART_ROM_MASK_RST;
         save_mask <= `CART_SAVE_MASK_RST;
      end else begin
         if (s_awvalid && s_awready) aw_hold <= 1'b1;
         else if (wr_go)             aw_hold <= 1'b0;
         if (s_wvalid && s_wready)   w_hold <= 1'b1;
         else if (wr_go)             w_hold <= 1'b0;

         if (wr_go) begin
            case (aw_addr_q)
               `CART_REG_MAPPER:    mapper_q  <= nxt_mapper[2:0];
               `CART_REG_ROM_MASK:  rom_mask  <= nxt_rom[`CART_PHYS_AW-1:0];
               `CART_REG_SAVE_MASK: save_mask <= nxt_save[`CART_PHYS_AW-1:0];
               default: ;
            endcase
         end

         if (wr_go)         s_bvalid <= 1'b1;
         else if (s_bready) s_bvalid <= 1'b0;
         if (rd_go)         s_rvalid <= 1'b1;
         else if (s_rready) s_rvalid <= 1'b0;
      end
   end

   // Captured channel payloads
   always_ff @(posedge clk) begin
      if (s_awvalid && s_awready) aw_addr_q <= s_awaddr;
      if (s_wvalid && s_wready) begin
         w_data_q <= s_wdata;
         w_strb_q <= s_wstrb;
      end
      if (wr_go) begin
         s_bresp <= (aw_addr_q inside {`CART_REG_MAPPER, `CART_REG_ROM_MASK,
                                       `CART_REG_SAVE_MASK}) ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_go) begin
         s_rdata <= rd_data;
         s_rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
      end
   end

   // Write response must wait for the master
   a_bvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
      s_bvalid && !s_bready |=> s_bvalid);

endmodule

// File: hw/address_map.sv
`timescale 1ns/1ps
`include "cart_cfg.svh"

module address_map (
   input  logic                     clk,
   input  logic                     rst_n,
   input  cart_pkg::mapper_e        mapper,
   input  logic [`CART_PHYS_AW-1:0] rom_mask,
   input  logic [`CART_PHYS_AW-1:0] save_mask,
   input  cart_pkg::bus_req_t       req,
   output cart_pkg::decode_t        dec
);
   import cart_pkg::*;

   logic [`CART_SNES_AW-1:0] a;
   logic                     sav_hi;     // HiROM/ExHiROM save window
   logic                     sav_lo;     // LoROM save window
   logic                     rom_hit;
   logic [14:0]              sav_off;    // Offset into 6000-7fff
   logic [`CART_PHYS_AW-1:0] rom_addr;
   logic                     known;
   decode_t                  dec_d;

   assign a = req.addr;

   ////////////////////////////////////////
   // Window classification
   ////////////////////////////////////////
   // Banks 30-3f/b0-bf, offset 6000-7fff, CART pin not driven there
   assign sav_hi  = !a[22] && (&a[21:20]) && !a[15] && (&a[14:13]);
   // Banks 70-7d/f0-fd lower half, 7e/7f are WRAM
   assign sav_lo  = (&a[22:20]) && (a[19:16] < 4'he) && !a[15] && !req.cs_n;
   assign rom_hit = a[22] || a[15];
   assign sav_off = a[14:0] - 15'h6000;

   always_comb begin
      known    = 1'b1;
      rom_addr = '0;
      dec_d    = '0;
      dec_d.valid = req.valid;
      case (mapper)
         map_hirom: begin
            dec_d.is_saveram = sav_hi;
            rom_addr = a[22:0];
         end
         map_lorom: begin
            dec_d.is_saveram = sav_lo;
            rom_addr = {1'b0, a[22:16], a[14:0]};   // 32 kB pages packed
         end
         map_exhirom: begin
            dec_d.is_saveram = sav_hi;
            rom_addr = {!a[23], a[21:0]};           // Upper 4 MB at banks 40-7d
         end
         default: known = 1'b0;   // Maps nothing
      endcase
      dec_d.is_rom = known && rom_hit;

      // Fold into the physical space
      if (!known)
         dec_d.phys_addr = '0;
      else if (dec_d.is_saveram && mapper == map_lorom)
         dec_d.phys_addr = `CART_PHYS_AW'(a[14:0]) & save_mask;
      else if (dec_d.is_saveram)
         dec_d.phys_addr = `CART_PHYS_AW'(sav_off) & save_mask;
      else
         dec_d.phys_addr = rom_addr & rom_mask;

      // Bank select
      if (req.master) begin
         dec_d.phys_addr = req.master_addr;   // Flags still from console address
         dec_d.bank_sel  = 1'b1;
         dec_d.bank      = req.master_addr[22:21];
      end else begin
         dec_d.bank_sel = dec_d.is_saveram || dec_d.is_rom;
         dec_d.bank     = dec_d.is_saveram ? 2'd3 : dec_d.phys_addr[22:21];  // Save RAM chip
      end
   end

   // One register stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) dec <= '0;
      else        dec <= dec_d;
   end

   // Save RAM only under a known layout, checked across the register
   a_no_save_unknown : assert property (@(posedge clk) disable iff (!rst_n)
      dec.is_saveram |-> $past(mapper) inside {map_hirom, map_lorom, map_exhirom});

endmodule

// File: hw/bank_port.sv
`timescale 1ns/1ps
`include "cart_cfg.svh"

module bank_port #(
   parameter int BANK_ID = 0
) (
   input  logic                clk,
   input  logic                rst_n,
   input  cart_pkg::decode_t   dec,
   output cart_pkg::bank_cmd_t chip_cmd,
   input  logic [15:0]         chip_data,
   output cart_pkg::bank_rsp_t brsp
);
   import cart_pkg::*;

   logic hit;   // This chip is addressed

   assign hit = dec.valid && dec.bank_sel && (dec.bank == 2'(BANK_ID));

   ////////////////////////////////////////
   // Chip command stage
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         chip_cmd <= '0;
      end else begin
         chip_cmd.sel       <= hit;
         chip_cmd.word_addr <= dec.phys_addr[`CART_WORD_AW:1];
         chip_cmd.lane      <= dec.phys_addr[0];
      end
   end

   // Capture stage, chip answers within the cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         brsp <= '0;
      end else begin
         brsp.valid <= chip_cmd.sel;
         if (!chip_cmd.sel)
            brsp.data <= 8'h00;                // Keeps the merge OR clean
         else if (chip_cmd.lane)
            brsp.data <= chip_data[15:8];      // Odd byte
         else
            brsp.data <= chip_data[7:0];
      end
   end

   a_capture_follows_sel : assert property (@(posedge clk) disable iff (!rst_n)
      brsp.valid == $past(chip_cmd.sel));

endmodule

// File: hw/bank_merge.sv
`timescale 1ns/1ps
`include "cart_cfg.svh"

module bank_merge (
   input  logic                clk,
   input  logic                rst_n,
   input  cart_pkg::bank_rsp_t brsp [`CART_NUM_BANKS],
   input  cart_pkg::decode_t   dec_d2,
   output cart_pkg::cart_rsp_t rsp
);
   import cart_pkg::*;

   logic [`CART_NUM_BANKS-1:0] hit_vec;    // Valid captures
   logic [7:0]                 byte_or;

   always_comb begin
      byte_or = 8'h00;   // No chip selected gives 0
      for (int i = 0; i < `CART_NUM_BANKS; i++) begin
         hit_vec[i] = brsp[i].valid;
         if (brsp[i].valid) byte_or = byte_or | brsp[i].data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp <= '0;
      end else begin
         rsp.valid      <= dec_d2.valid;
         rsp.is_rom     <= dec_d2.is_rom;
         rsp.is_saveram <= dec_d2.is_saveram;
         rsp.phys_addr  <= dec_d2.phys_addr;
         rsp.data       <= byte_or;
      end
   end

   // Decoder drives one select at most, two stages upstream
   a_one_bank : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(hit_vec));

endmodule

// File: hw/cart_mapper_top.sv
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_mapper_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`CART_AXI_AW-1:0]    s_awaddr,
   input  logic                       s_awvalid,
   output logic                       s_awready,
   input  logic [`CART_AXI_DW-1:0]    s_wdata,
   input  logic [`CART_AXI_DW/8-1:0]  s_wstrb,
   input  logic                       s_wvalid,
   output logic                       s_wready,
   output logic [1:0]                 s_bresp,
   output logic                       s_bvalid,
   input  logic                       s_bready,
   input  logic [`CART_AXI_AW-1:0]    s_araddr,
   input  logic                       s_arvalid,
   output logic                       s_arready,
   output logic [`CART_AXI_DW-1:0]    s_rdata,
   output logic [1:0]                 s_rresp,
   output logic                       s_rvalid,
   input  logic                       s_rready,
   input  cart_pkg::bus_req_t         req,
   output cart_pkg::cart_rsp_t        rsp,
   output cart_pkg::bank_cmd_t        chip_cmd [`CART_NUM_BANKS],
   input  logic [15:0]                chip_data [`CART_NUM_BANKS]
);
   import cart_pkg::*;

   mapper_e                  mapper;
   logic [`CART_PHYS_AW-1:0] rom_mask;
   logic [`CART_PHYS_AW-1:0] save_mask;
   decode_t                  dec;
   decode_t                  dec_d1;     // Aligned with chip command
   decode_t                  dec_d2;     // Aligned with capture
   bank_rsp_t                brsp [`CART_NUM_BANKS];

   cart_cfg_regs u_cfg (
      .clk, .rst_n,
      .s_awaddr, .s_awvalid, .s_awready,
      .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
      .s_bresp, .s_bvalid, .s_bready,
      .s_araddr, .s_arvalid, .s_arready,
      .s_rdata, .s_rresp, .s_rvalid, .s_rready,
      .mapper, .rom_mask, .save_mask
   );

   address_map u_amap (
      .clk, .rst_n, .mapper, .rom_mask, .save_mask, .req, .dec
   );

   ////////////////////////////////////////
   // One port per SRAM chip
   ////////////////////////////////////////
   for (genvar i = 0; i < `CART_NUM_BANKS; i++) begin : g_bank
      bank_port #(.BANK_ID(i)) u_port (
         .clk, .rst_n, .dec,
         .chip_cmd  (chip_cmd[i]),
         .chip_data (chip_data[i]),
         .brsp      (brsp[i])
      );
   end

   // Flags and address ride alongside the bank pipeline
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_d1 <= '0;
         dec_d2 <= '0;
      end else begin
         dec_d1 <= dec;
         dec_d2 <= dec_d1;
      end
   end

   bank_merge u_merge (
      .clk, .rst_n, .brsp, .dec_d2, .rsp
   );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD     = 100,   // ns
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset released on a rising edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// File: testbench/tb_cart_mapper.sv
`timescale 1ns/1ps
`include "cart_cfg.svh"

module tb_cart_mapper;
   import cart_pkg::*;

   localparam int HI_N  = 300;   // Requests per phase
   localparam int LO_N  = 250;
   localparam int EX_N  = 250;
   localparam int MS_N  = 200;
   localparam int UNK_N = 60;
   localparam int N_REQ = HI_N + LO_N + EX_N + MS_N + UNK_N + 1;
   localparam int N_AXI = 24;    // AXI transactions in the whole run
   localparam int LIMIT = N_REQ + 40 * N_AXI + 200;

   logic clk, rst_n;
   logic [31:0] s_awaddr, s_wdata, s_araddr, s_rdata;
   logic [3:0]  s_wstrb;
   logic [1:0]  s_bresp, s_rresp;
   logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
   logic s_arvalid, s_arready, s_rvalid, s_rready;
   bus_req_t    req;
   cart_rsp_t   rsp;
   bank_cmd_t   chip_cmd [`CART_NUM_BANKS];
   logic [15:0] chip_data [`CART_NUM_BANKS];

   cart_rsp_t   exp_q[$];        // Expected responses, in order
   int unsigned edge_q[$];       // Edge that drove each request
   int unsigned cyc = 0;
   int unsigned n_sent = 0;
   int unsigned n_recv = 0;
   logic [31:0] rng = 32'h85de;
   logic [2:0]  m_map;           // Register model
   logic [22:0] m_rom;
   logic [22:0] m_save;

   tb_clock_gen #(.PERIOD(100), .RST_CYCLES(4)) u_clk (.clk, .rst_n);

   cart_mapper_top dut (.*);

   // Chip models, word is {chip number, low word address bits}
   for (genvar i = 0; i < `CART_NUM_BANKS; i++) begin : g_chip
      assign chip_data[i] = {2'(i), chip_cmd[i].word_addr[13:0]};
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic compare_val(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
         abort_run("first error reached, stopping");
      end
   endtask

   // Byte strobes over a 32-bit register image
   function automatic logic [31:0] apply_strobes(input logic [31:0] old_v,
                                                 input logic [31:0] new_v,
                                                 input logic [3:0] strb);
      logic [31:0] v;
      v = old_v;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) v[8*b +: 8] = new_v[8*b +: 8];
      end
      return v;
   endfunction

   // Expected response from the mapper rules and the chip model
   function automatic cart_rsp_t ref_rsp(input logic [23:0] a, input logic cs_n,
                                         input logic master, input logic [22:0] maddr,
                                         input logic [2:0] map, input logic [22:0] rmask,
                                         input logic [22:0] smask);
      cart_rsp_t   r;
      logic        known, sav, rom, hit;
      logic [22:0] pa;
      logic [1:0]  bk;
      logic [15:0] word;
      r     = '0;
      known = (map <= 3'd2);
      sav   = 1'b0;
      if (map == 3'(map_hirom) || map == 3'(map_exhirom))
         sav = !a[22] && a[21:20] == 2'b11 && !a[15] && a[14:13] == 2'b11;
      else if (map == 3'(map_lorom))
         sav = a[22:20] == 3'b111 && a[19:16] < 4'he && !a[15] && !cs_n;
      rom = known && (a[22] || a[15]);
      pa  = '0;
      if (known) begin
         if (sav && map == 3'(map_lorom))
            pa = {8'h00, a[14:0]} & smask;
         else if (sav)
            pa = {8'h00, a[14:0] - 15'h6000} & smask;   // Window starts at 6000
         else if (map == 3'(map_hirom))
            pa = a[22:0] & rmask;
         else if (map == 3'(map_lorom))
            pa = {1'b0, a[22:16], a[14:0]} & rmask;
         else
            pa = {~a[23], a[21:0]} & rmask;
      end
      if (master) begin
         pa  = maddr;                // Flags stay with the console address
         hit = 1'b1;
         bk  = maddr[22:21];
      end else begin
         hit = sav || rom;
         bk  = sav ? 2'd3 : pa[22:21];
      end
      word         = {bk, pa[14:1]};
      r.valid      = 1'b1;
      r.is_rom     = rom;
      r.is_saveram = sav;
      r.phys_addr  = pa;
      r.data       = !hit ? 8'h00 : (pa[0] ? word[15:8] : word[7:0]);
      return r;
   endfunction

   ////////////////////////////////////////
   // AXI4-Lite master
   ////////////////////////////////////////
   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
      logic aw_done;
      logic w_done;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge clk);
      s_awaddr  <= addr;
      s_awvalid <= 1'b1;
      s_wdata   <= data;
      s_wstrb   <= strb;
      s_wvalid  <= 1'b1;
      while (!(aw_done && w_done)) begin
         @(posedge clk);
         if (s_awvalid && s_awready) begin
            aw_done = 1'b1;
            s_awvalid <= 1'b0;
         end
         if (s_wvalid && s_wready) begin
            w_done = 1'b1;
            s_wvalid <= 1'b0;
         end
      end
      do @(posedge clk); while (!s_bvalid);
      compare_val("s_bresp", s_bresp, exp_resp);
      s_bready <= 1'b1;          // Response sat one edge with BREADY low
      @(posedge clk);
      compare_val("s_bvalid", s_bvalid, 1'b1);
      s_bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
      @(posedge clk);
      s_araddr  <= addr;
      s_arvalid <= 1'b1;
      s_rready  <= 1'b1;
      do @(posedge clk); while (!(s_arvalid && s_arready));
      s_arvalid <= 1'b0;
      do @(posedge clk); while (!s_rvalid);
      compare_val("s_rresp", s_rresp, exp_resp);
      if (exp_resp == 2'b00) compare_val("s_rdata", s_rdata, exp_data);
      s_rready <= 1'b0;
   endtask

   // Write through the port and mirror it into the model
   task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic mapped;
      mapped = addr inside {`CART_REG_MAPPER, `CART_REG_ROM_MASK, `CART_REG_SAVE_MASK};
      axi_write(addr, data, strb, mapped ? 2'b00 : 2'b10);
      if (addr == `CART_REG_MAPPER)
         m_map = apply_strobes({29'd0, m_map}, data, strb);
      else if (addr == `CART_REG_ROM_MASK)
         m_rom = apply_strobes({9'd0, m_rom}, data, strb);
      else if (addr == `CART_REG_SAVE_MASK)
         m_save = apply_strobes({9'd0, m_save}, data, strb);
   endtask

   task automatic cfg_readback(input logic [31:0] addr);
      if (addr == `CART_REG_MAPPER)         axi_read(addr, {29'd0, m_map}, 2'b00);
      else if (addr == `CART_REG_ROM_MASK)  axi_read(addr, {9'd0, m_rom}, 2'b00);
      else if (addr == `CART_REG_SAVE_MASK) axi_read(addr, {9'd0, m_save}, 2'b00);
      else                                  axi_read(addr, 32'd0, 2'b10);
   endtask

   ////////////////////////////////////////
   // Console bus stimulus
   ////////////////////////////////////////
   task automatic drive_req(input logic [23:0] addr, input logic cs_n,
                            input logic master, input logic [22:0] maddr);
      bus_req_t r;
      r.valid       = 1'b1;
      r.addr        = addr;
      r.cs_n        = cs_n;
      r.master      = master;
      r.master_addr = maddr;
      @(posedge clk);
      req <= r;
      exp_q.push_back(ref_rsp(addr, cs_n, master, maddr, m_map, m_rom, m_save));
      edge_q.push_back(cyc + 1);   // Edge being driven now
      n_sent++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         req <= '0;
      end
   endtask

   task automatic drain_pipe();
      idle_cycles(1);
      while (exp_q.size() != 0) @(posedge clk);
      idle_cycles(2);
   endtask

   // Bursts biased toward the save-RAM windows
   task automatic random_stream(input int n, input logic master_on);
      logic [31:0] r1, r2;
      logic [23:0] a;
      for (int k = 0; k < n; k++) begin
         rng = lcg_step(rng);
         r1  = rng;
         rng = lcg_step(rng);
         r2  = rng;
         a   = r1[31:8];         // Upper LCG bits only
         case (r2[17:16])
            2'd0: a = {a[23], 1'b0, 2'b11, a[19:16], 1'b0, 2'b11, a[12:0]};
            2'd1: a = {a[23], 3'b111, a[19:16], 1'b0, a[14:0]};   // Includes 7e/7f
            default: ;
         endcase
         drive_req(a, r2[18], master_on && r2[19], r2[31:9]);
      end
      drain_pipe();
   endtask

   ////////////////////////////////////////
   // Response checker and run limit
   ////////////////////////////////////////
   always @(negedge clk) begin
      cart_rsp_t   e;
      int unsigned d;
      if (rst_n && rsp.valid) begin
         if (exp_q.size() == 0)
            abort_run("response arrived with no request outstanding");
         e = exp_q.pop_front();
         d = edge_q.pop_front();
         n_recv++;
         compare_val("rsp.is_rom", rsp.is_rom, e.is_rom);
         compare_val("rsp.is_saveram", rsp.is_saveram, e.is_saveram);
         compare_val("rsp.phys_addr", rsp.phys_addr, e.phys_addr);
         compare_val("rsp.data", rsp.data, e.data);
         compare_val("rsp latency", cyc - d, 4);
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) abort_run("timeout, run exceeded its cycle limit");
   end

   initial begin
      req       = '0;
      s_awaddr  = '0;
      s_awvalid = 1'b0;
      s_wdata   = '0;
      s_wstrb   = '0;
      s_wvalid  = 1'b0;
      s_bready  = 1'b0;
      s_araddr  = '0;
      s_arvalid = 1'b0;
      s_rready  = 1'b0;
      m_map     = 3'(map_hirom);
      m_rom     = `CART_ROM_MASK_RST;
      m_save    = `CART_SAVE_MASK_RST;
      @(posedge clk);
      while (!rst_n) @(posedge clk);

      // Register reset values, strobes, field widths, unmapped offset
      cfg_readback(`CART_REG_MAPPER);
      cfg_readback(`CART_REG_ROM_MASK);
      cfg_readback(`CART_REG_SAVE_MASK);
      cfg_write(`CART_REG_MAPPER, 32'hffff_fffa, 4'b1111);
      cfg_readback(`CART_REG_MAPPER);
      cfg_write(`CART_REG_MAPPER, 32'h0000_0101, 4'b0010);   // Byte 1 only
      cfg_readback(`CART_REG_MAPPER);
      cfg_write(`CART_REG_ROM_MASK, 32'hffff_00f0, 4'b0101);
      cfg_readback(`CART_REG_ROM_MASK);
      cfg_write(`CART_REG_SAVE_MASK, 32'h1234_5678, 4'b1100);
      cfg_readback(`CART_REG_SAVE_MASK);
      cfg_write(32'h0000_000c, 32'hdead_beef, 4'b1111);
      cfg_readback(32'h0000_0010);

      // HiROM with reset masks
      cfg_write(`CART_REG_MAPPER, 32'(map_hirom), 4'b0001);
      cfg_write(`CART_REG_ROM_MASK, 32'h007f_ffff, 4'b1111);
      cfg_write(`CART_REG_SAVE_MASK, 32'h0000_1fff, 4'b1111);
      random_stream(HI_N, 1'b0);

      // LoROM, 2 MB image, 2 kB save
      cfg_write(`CART_REG_MAPPER, 32'(map_lorom), 4'b0001);
      cfg_write(`CART_REG_ROM_MASK, 32'h001f_ffff, 4'b1111);
      cfg_write(`CART_REG_SAVE_MASK, 32'h0000_07ff, 4'b1111);
      random_stream(LO_N, 1'b0);

      // ExHiROM, 7 MB style mask
      cfg_write(`CART_REG_MAPPER, 32'(map_exhirom), 4'b0001);
      cfg_write(`CART_REG_ROM_MASK, 32'h006f_ffff, 4'b1111);
      cfg_write(`CART_REG_SAVE_MASK, 32'h0000_0fff, 4'b1111);
      random_stream(EX_N, 1'b0);

      // Controller cycles mixed into console traffic
      cfg_write(`CART_REG_MAPPER, 32'(map_lorom), 4'b0001);
      random_stream(MS_N, 1'b1);

      // Unknown code maps nothing
      cfg_write(`CART_REG_MAPPER, 32'h0000_0005, 4'b0001);
      random_stream(UNK_N, 1'b0);
      idle_cycles(1);
      drive_req(24'hc0_8000, 1'b0, 1'b0, 23'd0);
      idle_cycles(1);
      drain_pipe();
      idle_cycles(4);

      if (n_sent != n_recv || exp_q.size() != 0)
         abort_run("response count does not match request count");
      else begin
         $display("Test completed successfully");
         $finish;
      end
   end

endmodule

// File: cart_mapper_top.f
+incdir+hw
hw/cart_pkg.sv
hw/cart_cfg_regs.sv
hw/address_map.sv
hw/bank_port.sv
hw/bank_merge.sv
hw/cart_mapper_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cart_mapper.sv
